//--- build.f
source/ccu_pkg.sv
source/cd_order_if.sv
source/cd_order_queue.sv
source/cd_beat_collector.sv
source/inflight_table.sv
source/ccu_data_path.sv
+incdir+verification
verification/ccu_data_path_tb.sv

//--- source/ccu_data_path.sv
////////////////////////////////////////
// CCU data path top
// Snoop data ordering plus write and read collision tables
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ccu_data_path #(
    parameter int unsigned NumMst        = 4,
    parameter int unsigned CdQueueDepth  = 4,
    parameter int unsigned TableCapacity = 6,
    parameter int unsigned IdWidth       = 4,
    localparam int unsigned MstIdxWidth  = (NumMst > 1) ? $clog2(NumMst) : 1
) (
    input  wire logic                                      clk_i,
    input  wire logic                                      rst_ni,
    // Ordering entry push
    input  wire logic                                      cd_push_i,
    input  wire ccu_pkg::cd_user_e                         cd_user_i,
    input  wire logic [MstIdxWidth-1:0]                    cd_first_i,
    input  wire logic [NumMst-1:0]                         cd_avail_i,
    output logic                                           cd_stall_o,
    // Snoop data from the masters
    input  wire logic [NumMst-1:0]                         cd_valid_i,
    input  wire logic [NumMst-1:0]                         cd_last_i,
    input  wire ccu_pkg::cd_data_t [NumMst-1:0]            cd_data_i,
    output logic [NumMst-1:0]                              cd_ready_o,
    // Consumers
    input  wire logic                                      mu_full_i,
    input  wire logic                                      su_full_i,
    output logic                                           mu_valid_o,
    output logic                                           mu_last_o,
    output logic                                           su_valid_o,
    output logic                                           su_last_o,
    output ccu_pkg::cd_data_t                              cd_data_o,
    // Write table
    input  wire logic                                      wr_issue_i,
    input  wire logic [IdWidth-1:0]                        wr_id_i,
    input  wire logic [ccu_pkg::AddrWidth-1:0]             wr_addr_i,
    output logic                                           wr_full_o,
    input  wire logic                                      wr_done_i,
    input  wire logic [IdWidth-1:0]                        wr_done_id_i,
    // Read table
    input  wire logic                                      rd_issue_i,
    input  wire logic [IdWidth-1:0]                        rd_id_i,
    input  wire logic [ccu_pkg::AddrWidth-1:0]             rd_addr_i,
    output logic                                           rd_full_o,
    input  wire logic                                      rd_done_i,
    input  wire logic [IdWidth-1:0]                        rd_done_id_i,
    // Collision lookup
    input  wire logic [NumMst-1:0]                         lookup_req_i,
    input  wire logic [NumMst-1:0][ccu_pkg::AddrWidth-1:0] lookup_addr_i,
    output logic [NumMst-1:0]                              lookup_hit_o
);

    logic [NumMst-1:0] wr_hit;
    logic [NumMst-1:0] rd_hit;

    cd_order_if #(.NumMst(NumMst)) ord_if ();

    ////////////////////////////////////////
    // Snoop data ordering
    ////////////////////////////////////////

    cd_order_queue #(
        .NumMst       (NumMst),
        .CdQueueDepth (CdQueueDepth)
    ) cd_order_queue_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (cd_push_i),
        .user_i  (cd_user_i),
        .first_i (cd_first_i),
        .avail_i (cd_avail_i),
        .full_o  (cd_stall_o),
        .ord     (ord_if.producer)
    );

    cd_beat_collector #(
        .NumMst (NumMst)
    ) cd_beat_collector_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ord        (ord_if.consumer),
        .cd_valid_i (cd_valid_i),
        .cd_last_i  (cd_last_i),
        .cd_data_i  (cd_data_i),
        .cd_ready_o (cd_ready_o),
        .mu_full_i  (mu_full_i),
        .su_full_i  (su_full_i),
        .mu_valid_o (mu_valid_o),
        .mu_last_o  (mu_last_o),
        .su_valid_o (su_valid_o),
        .su_last_o  (su_last_o),
        .cd_data_o  (cd_data_o)
    );

    ////////////////////////////////////////
    // Collision check
    ////////////////////////////////////////

    inflight_table #(
        .TableCapacity (TableCapacity),
        .IdWidth       (IdWidth),
        .NumMst        (NumMst)
    ) wr_table_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .issue_i       (wr_issue_i),
        .issue_id_i    (wr_id_i),
        .issue_addr_i  (wr_addr_i),
        .full_o        (wr_full_o),
        .done_i        (wr_done_i),
        .done_id_i     (wr_done_id_i),
        .lookup_req_i  (lookup_req_i),
        .lookup_addr_i (lookup_addr_i),
        .hit_o         (wr_hit)
    );

    inflight_table #(
        .TableCapacity (TableCapacity),
        .IdWidth       (IdWidth),
        .NumMst        (NumMst)
    ) rd_table_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .issue_i       (rd_issue_i),
        .issue_id_i    (rd_id_i),
        .issue_addr_i  (rd_addr_i),
        .full_o        (rd_full_o),
        .done_i        (rd_done_i),
        .done_id_i     (rd_done_id_i),
        .lookup_req_i  (lookup_req_i),
        .lookup_addr_i (lookup_addr_i),
        .hit_o         (rd_hit)
    );

    // A line in flight in either direction collides
    assign lookup_hit_o = wr_hit | rd_hit;

endmodule

`default_nettype wire

//--- source/ccu_pkg.sv
////////////////////////////////////////
// Shared widths and types of the CCU data path
// Consumer enum for snoop data streams
////////////////////////////////////////

`default_nettype none

package ccu_pkg;

    ////////////////////////////////////////
    // Snoop data consumers
    ////////////////////////////////////////

    typedef enum logic {
        MEMORY_UNIT = 1'b0,
        SNOOP_UNIT  = 1'b1
    } cd_user_e;

    ////////////////////////////////////////
    // Address and cache line geometry
    ////////////////////////////////////////

    localparam int unsigned AddrWidth = 32;

    // 64-byte lines
    localparam int unsigned LineOffset = 6;

    localparam int unsigned LineIdxWidth = 10;

    typedef logic [LineIdxWidth-1:0] line_idx_t;

    ////////////////////////////////////////
    // Snoop data beats
    ////////////////////////////////////////

    localparam int unsigned CdDataWidth = 64;

    typedef logic [CdDataWidth-1:0] cd_data_t;

endpackage

`default_nettype wire

//--- source/cd_beat_collector.sv
////////////////////////////////////////
// Snoop data beat collector
// Per-master last tracking, ready and routing to MU or SU
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cd_beat_collector #(
    parameter int unsigned NumMst = 4
) (
    input  wire logic                           clk_i,
    input  wire logic                           rst_ni,
    cd_order_if.consumer                        ord,
    // Snoop data from the masters
    input  wire logic [NumMst-1:0]              cd_valid_i,
    input  wire logic [NumMst-1:0]              cd_last_i,
    input  wire ccu_pkg::cd_data_t [NumMst-1:0] cd_data_i,
    output logic [NumMst-1:0]                   cd_ready_o,
    // Consumers
    input  wire logic                           mu_full_i,
    input  wire logic                           su_full_i,
    output logic                                mu_valid_o,
    output logic                                mu_last_o,
    output logic                                su_valid_o,
    output logic                                su_last_o,
    output ccu_pkg::cd_data_t                   cd_data_o
);

    logic [NumMst-1:0] last_q;
    logic [NumMst-1:0] accept;
    logic              cons_full;
    logic              first_accept;
    logic              first_last;

    // Back-pressure from the consumer named in the head
    assign cons_full = (ord.head_user == ccu_pkg::SNOOP_UNIT) ? su_full_i : mu_full_i;

    ////////////////////////////////////////
    // Ready generation
    ////////////////////////////////////////

    for (genvar i = 0; i < NumMst; i++) begin : gen_ready
        logic is_first;

        assign is_first = (int'(ord.head_first) == i);

        // Only the first responder waits for the consumer
        assign cd_ready_o[i] = ord.head_valid && ord.head_avail[i] && !last_q[i]
                               && !(is_first && cons_full);
    end

    assign accept = cd_valid_i & cd_ready_o;

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////

    assign first_accept = accept[ord.head_first];
    assign first_last   = cd_last_i[ord.head_first];

    assign mu_valid_o = first_accept && (ord.head_user == ccu_pkg::MEMORY_UNIT);
    assign su_valid_o = first_accept && (ord.head_user == ccu_pkg::SNOOP_UNIT);
    assign mu_last_o  = mu_valid_o && first_last;
    assign su_last_o  = su_valid_o && first_last;

    // Data bus shared by both consumers
    assign cd_data_o = cd_data_i[ord.head_first];

    ////////////////////////////////////////
    // Last tracking and retire
    ////////////////////////////////////////

    // Zero mask retires as soon as it reaches the head
    assign ord.retire = ord.head_valid && (last_q == ord.head_avail);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= '0;
        end else if (ord.retire) begin
            last_q <= '0;
        end else begin
            last_q <= last_q | (accept & cd_last_i);
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) !(mu_valid_o && su_valid_o))
        else $error("both consumers see a snoop data beat");

endmodule

`default_nettype wire

//--- source/cd_order_if.sv
////////////////////////////////////////
// Head entry of the snoop data ordering queue
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface cd_order_if #(
    parameter int unsigned NumMst = 4
);

    localparam int unsigned MstIdxWidth = (NumMst > 1) ? $clog2(NumMst) : 1;

    logic                   head_valid;
    ccu_pkg::cd_user_e      head_user;
    logic [MstIdxWidth-1:0] head_first;
    logic [NumMst-1:0]      head_avail;
    // Pops the head
    logic                   retire;

    modport producer (
        output head_valid, head_user, head_first, head_avail,
        input  retire
    );

    modport consumer (
        input  head_valid, head_user, head_first, head_avail,
        output retire
    );

endinterface

`default_nettype wire

//--- source/cd_order_queue.sv
////////////////////////////////////////
// Fall-through FIFO of snoop data ordering entries
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cd_order_queue #(
    parameter int unsigned NumMst       = 4,
    parameter int unsigned CdQueueDepth = 4,
    localparam int unsigned MstIdxWidth = (NumMst > 1) ? $clog2(NumMst) : 1
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   push_i,
    input  wire ccu_pkg::cd_user_e      user_i,
    input  wire logic [MstIdxWidth-1:0] first_i,
    input  wire logic [NumMst-1:0]      avail_i,
    output logic                        full_o,
    cd_order_if.producer                ord
);

    localparam int unsigned PtrWidth = (CdQueueDepth > 1) ? $clog2(CdQueueDepth) : 1;
    localparam int unsigned CntWidth = $clog2(CdQueueDepth + 1);

    typedef logic [PtrWidth-1:0] ptr_t;

    ptr_t                   rd_ptr_q;
    ptr_t                   wr_ptr_q;
    logic [CntWidth-1:0]    count_q;
    ccu_pkg::cd_user_e      user_q  [CdQueueDepth];
    logic [MstIdxWidth-1:0] first_q [CdQueueDepth];
    logic [NumMst-1:0]      avail_q [CdQueueDepth];
    logic                   empty;
    logic                   do_push;
    logic                   do_pop;
    logic                   bypass;
    logic                   wr_en;
    logic                   rd_en;

    function automatic ptr_t ptr_next(input ptr_t ptr);
        if (ptr == ptr_t'(CdQueueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty   = (count_q == '0);
    assign full_o  = (count_q == CntWidth'(CdQueueDepth));
    assign do_push = push_i && !full_o;
    assign do_pop  = ord.retire && ord.head_valid;
    // Entry pushed and retired in the same cycle never gets stored
    assign bypass  = empty && do_push && do_pop;
    assign wr_en   = do_push && !bypass;
    assign rd_en   = do_pop && !bypass;

    // Head falls through from the inputs while empty
    assign ord.head_valid = !empty || do_push;
    assign ord.head_user  = empty ? user_i  : user_q[rd_ptr_q];
    assign ord.head_first = empty ? first_i : first_q[rd_ptr_q];
    assign ord.head_avail = empty ? avail_i : avail_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (rd_en) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            count_q <= count_q + CntWidth'(wr_en) - CntWidth'(rd_en);
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            user_q[wr_ptr_q]  <= user_i;
            first_q[wr_ptr_q] <= first_i;
            avail_q[wr_ptr_q] <= avail_i;
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    // Collector may only retire an entry that exists
    assert property (@(posedge clk_i) disable iff (!rst_ni) ord.retire |-> ord.head_valid)
        else $error("retire pulsed while ordering queue is empty");

    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
        else $error("push dropped while ordering queue is stalled");

endmodule

`default_nettype wire

//--- source/inflight_table.sv
////////////////////////////////////////
// ID-tagged table of in-flight line indices
// Per-master lookup ports for the collision check
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module inflight_table #(
    parameter int unsigned TableCapacity = 6,
    parameter int unsigned IdWidth       = 4,
    parameter int unsigned NumMst        = 4
) (
    input  wire logic                                      clk_i,
    input  wire logic                                      rst_ni,
    // Insert
    input  wire logic                                      issue_i,
    input  wire logic [IdWidth-1:0]                        issue_id_i,
    input  wire logic [ccu_pkg::AddrWidth-1:0]             issue_addr_i,
    output logic                                           full_o,
    // Remove
    input  wire logic                                      done_i,
    input  wire logic [IdWidth-1:0]                        done_id_i,
    // Lookup
    input  wire logic [NumMst-1:0]                         lookup_req_i,
    input  wire logic [NumMst-1:0][ccu_pkg::AddrWidth-1:0] lookup_addr_i,
    output logic [NumMst-1:0]                              hit_o
);

    logic [TableCapacity-1:0] valid_q;
    logic [IdWidth-1:0]       id_q  [TableCapacity];
    ccu_pkg::line_idx_t       idx_q [TableCapacity];
    ccu_pkg::line_idx_t       issue_idx;
    logic [TableCapacity-1:0] ins_sel;
    logic [TableCapacity-1:0] rem_sel;
    logic                     ins_found;
    logic                     rem_found;

    assign issue_idx = issue_addr_i[ccu_pkg::LineOffset +: ccu_pkg::LineIdxWidth];
    assign full_o    = &valid_q;

    // Lowest free slot for insert, lowest matching ID for remove
    always_comb begin
        ins_sel   = '0;
        rem_sel   = '0;
        ins_found = 1'b0;
        rem_found = 1'b0;
        for (int e = 0; e < TableCapacity; e++) begin
            if (!valid_q[e] && !ins_found) begin
                ins_sel[e] = 1'b1;
                ins_found  = 1'b1;
            end
            if (valid_q[e] && (id_q[e] == done_id_i) && !rem_found) begin
                rem_sel[e] = 1'b1;
                rem_found  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q | (issue_i ? ins_sel : '0)) & ~(done_i ? rem_sel : '0);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int e = 0; e < TableCapacity; e++) begin
            if (issue_i && ins_sel[e]) begin
                id_q[e]  <= issue_id_i;
                idx_q[e] <= issue_idx;
            end
        end
    end

    ////////////////////////////////////////
    // Lookup compare
    ////////////////////////////////////////

    for (genvar p = 0; p < NumMst; p++) begin : gen_lookup
        ccu_pkg::line_idx_t       lookup_idx;
        logic [TableCapacity-1:0] match;

        assign lookup_idx = lookup_addr_i[p][ccu_pkg::LineOffset +: ccu_pkg::LineIdxWidth];

        for (genvar e = 0; e < TableCapacity; e++) begin : gen_cmp
            assign match[e] = valid_q[e] && (idx_q[e] == lookup_idx);
        end

        assign hit_o[p] = lookup_req_i[p] && |match;
    end

    // Completion must belong to a transaction in flight
    assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |-> rem_found)
        else $error("done for ID %0h not present in table", done_id_i);

endmodule

`default_nettype wire

//--- verification/ccu_data_path_tb_table.svh
////////////////////////////////////////
// Stimulus and expected-value rows
// Payload generator for snoop data beats
////////////////////////////////////////

`ifndef CCU_DATA_PATH_TB_TABLE_SVH
`define CCU_DATA_PATH_TB_TABLE_SVH

localparam logic MU = 1'b0;
localparam logic SU = 1'b1;

// Table operations
localparam logic [2:0] OP_NONE  = 3'd0;
localparam logic [2:0] OP_WR_IS = 3'd1;
localparam logic [2:0] OP_WR_DN = 3'd2;
localparam logic [2:0] OP_RD_IS = 3'd3;
localparam logic [2:0] OP_RD_DN = 3'd4;

typedef struct {
    logic        push;
    logic        user;
    logic [1:0]  first;
    logic [3:0]  avail;
    logic [3:0]  valid;
    logic [3:0]  last;
    logic        mu_full;
    logic        su_full;
    logic [3:0]  exp_ready;
    logic        exp_mu;
    logic        exp_su;
    logic        exp_last;
    logic        exp_stall;
    logic [2:0]  op;
    logic [3:0]  id;
    logic [31:0] addr;
    logic [3:0]  lk_req;
    logic [31:0] lk_addr;
    logic        exp_hit;
    logic        exp_wfull;
    logic        exp_rfull;
} row_t;

row_t rows[$];
logic [31:0] rand_state = 32'h08ceefca;

function automatic logic [31:0] lcg_next();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
endfunction

// Snoop data row; tables idle and empty
function automatic void add_cd_row(
    input logic push, input logic user, input logic [1:0] first,
    input logic [3:0] avail, input logic [3:0] valid, input logic [3:0] last,
    input logic mu_full, input logic su_full, input logic [3:0] exp_ready,
    input logic exp_mu, input logic exp_su, input logic exp_last, input logic exp_stall
);
    row_t r;
    r = '{push, user, first, avail, valid, last, mu_full, su_full, exp_ready,
          exp_mu, exp_su, exp_last, exp_stall, OP_NONE, 4'h0, 32'h0, 4'h0, 32'h0,
          1'b0, 1'b0, 1'b0};
    rows.push_back(r);
endfunction

// Table row; lookup on every port, ordering queue empty
function automatic void add_tbl_row(
    input logic [2:0] op, input logic [3:0] id, input logic [31:0] addr,
    input logic [31:0] lk_addr, input logic exp_hit, input logic exp_wfull,
    input logic exp_rfull
);
    row_t r;
    r = '{1'b0, MU, 2'd0, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0,
          1'b0, op, id, addr, 4'hf, lk_addr, exp_hit, exp_wfull, exp_rfull};
    rows.push_back(r);
endfunction

function automatic void build_table();
    // Routing to SU, master 1 drained but not forwarded
    add_cd_row(1, SU, 2, 4'b0110, 4'b0110, 4'b0000, 0, 0, 4'b0110, 0, 1, 0, 0);
    add_cd_row(0, SU, 2, 4'b0000, 4'b0110, 4'b0100, 0, 0, 4'b0110, 0, 1, 1, 0);
    add_cd_row(0, SU, 2, 4'b0000, 4'b0010, 4'b0010, 0, 0, 4'b0010, 0, 0, 0, 0);
    add_cd_row(0, SU, 2, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0000, 0, 0, 0, 0);
    add_cd_row(0, MU, 0, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0000, 0, 0, 0, 0);
    // Back-pressure on the first responder
    add_cd_row(1, SU, 0, 4'b0011, 4'b0011, 4'b0011, 0, 1, 4'b0010, 0, 0, 0, 0);
    add_cd_row(0, SU, 0, 4'b0000, 4'b0001, 4'b0001, 0, 1, 4'b0000, 0, 0, 0, 0);
    add_cd_row(0, SU, 0, 4'b0000, 4'b0001, 4'b0001, 0, 0, 4'b0001, 0, 1, 1, 0);
    add_cd_row(0, SU, 0, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0000, 0, 0, 0, 0);
    add_cd_row(0, MU, 0, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0000, 0, 0, 0, 0);
    // Four entries, stall, served in order, zero mask retires silently
    add_cd_row(1, MU, 1, 4'b0010, 4'b0000, 4'b0000, 0, 0, 4'b0010, 0, 0, 0, 0);
    add_cd_row(1, SU, 3, 4'b1000, 4'b0000, 4'b0000, 0, 0, 4'b0010, 0, 0, 0, 0);
    add_cd_row(1, MU, 0, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0010, 0, 0, 0, 0);
    add_cd_row(1, SU, 2, 4'b0100, 4'b0000, 4'b0000, 0, 0, 4'b0010, 0, 0, 0, 0);
    add_cd_row(0, MU, 1, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0010, 0, 0, 0, 1);
    add_cd_row(0, MU, 1, 4'b0000, 4'b0010, 4'b0010, 0, 0, 4'b0010, 1, 0, 1, 1);
    add_cd_row(0, MU, 1, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0000, 0, 0, 0, 1);
    add_cd_row(0, SU, 3, 4'b0000, 4'b1000, 4'b1000, 0, 0, 4'b1000, 0, 1, 1, 0);
    add_cd_row(0, SU, 3, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0000, 0, 0, 0, 0);
    add_cd_row(0, MU, 0, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0000, 0, 0, 0, 0);
    add_cd_row(0, SU, 2, 4'b0000, 4'b0100, 4'b0100, 0, 0, 4'b0100, 0, 1, 1, 0);
    add_cd_row(0, SU, 2, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0000, 0, 0, 0, 0);
    add_cd_row(0, MU, 0, 4'b0000, 4'b0000, 4'b0000, 0, 0, 4'b0000, 0, 0, 0, 0);
    // Write table collision
    add_tbl_row(OP_WR_IS, 4'h3, 32'h0000_1240, 32'h0000_1240, 0, 0, 0);
    add_tbl_row(OP_NONE,  4'h0, 32'h0,         32'h0000_1270, 1, 0, 0);
    add_tbl_row(OP_NONE,  4'h0, 32'h0,         32'h0000_1280, 0, 0, 0);
    add_tbl_row(OP_WR_DN, 4'h3, 32'h0,         32'h0000_1250, 1, 0, 0);
    add_tbl_row(OP_NONE,  4'h0, 32'h0,         32'h0000_1250, 0, 0, 0);
    // Read table collision
    add_tbl_row(OP_RD_IS, 4'h5, 32'h0000_8a00, 32'h0000_8a00, 0, 0, 0);
    add_tbl_row(OP_NONE,  4'h0, 32'h0,         32'h0000_8a30, 1, 0, 0);
    add_tbl_row(OP_NONE,  4'h0, 32'h0,         32'h0000_8a40, 0, 0, 0);
    add_tbl_row(OP_RD_DN, 4'h5, 32'h0,         32'h0000_8a10, 1, 0, 0);
    add_tbl_row(OP_NONE,  4'h0, 32'h0,         32'h0000_8a10, 0, 0, 0);
    // Write table capacity, seventh issue dropped
    for (int k = 0; k < 6; k++) begin
        add_tbl_row(OP_WR_IS, 4'(k), 32'h0000_1000 + 32'(k) * 32'h40, 32'h0, 0, 0, 0);
    end
    add_tbl_row(OP_WR_IS, 4'h6, 32'h0000_2000, 32'h0000_2000, 0, 1, 0);
    add_tbl_row(OP_NONE,  4'h0, 32'h0,         32'h0000_2000, 0, 1, 0);
    add_tbl_row(OP_NONE,  4'h0, 32'h0,         32'h0000_1140, 1, 1, 0);
endfunction

`endif

//--- verification/ccu_data_path_tb.sv
////////////////////////////////////////
// Testbench for the CCU data path
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ccu_data_path_tb;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    cd_push_i;
    ccu_pkg::cd_user_e       cd_user_i;
    logic [1:0]              cd_first_i;
    logic [3:0]              cd_avail_i;
    logic                    cd_stall_o;
    logic [3:0]              cd_valid_i;
    logic [3:0]              cd_last_i;
    ccu_pkg::cd_data_t [3:0] cd_data_i;
    logic [3:0]              cd_ready_o;
    logic                    mu_full_i;
    logic                    su_full_i;
    logic                    mu_valid_o;
    logic                    mu_last_o;
    logic                    su_valid_o;
    logic                    su_last_o;
    ccu_pkg::cd_data_t       cd_data_o;
    logic                    wr_issue_i;
    logic [3:0]              wr_id_i;
    logic [31:0]             wr_addr_i;
    logic                    wr_full_o;
    logic                    wr_done_i;
    logic [3:0]              wr_done_id_i;
    logic                    rd_issue_i;
    logic [3:0]              rd_id_i;
    logic [31:0]             rd_addr_i;
    logic                    rd_full_o;
    logic                    rd_done_i;
    logic [3:0]              rd_done_id_i;
    logic [3:0]              lookup_req_i;
    logic [3:0][31:0]        lookup_addr_i;
    logic [3:0]              lookup_hit_o;

    int                errors = 0;
    ccu_pkg::cd_data_t expected_beats[$];

    `include "ccu_data_path_tb_table.svh"

    ccu_data_path #(
        .NumMst        (4),
        .CdQueueDepth  (4),
        .TableCapacity (6),
        .IdWidth       (4)
    ) ccu_data_path_inst (.*);

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic drive_row(input row_t r);
        ccu_pkg::cd_data_t beat;
        cd_push_i    <= r.push;
        cd_user_i    <= ccu_pkg::cd_user_e'(r.user);
        cd_first_i   <= r.first;
        cd_avail_i   <= r.avail;
        cd_valid_i   <= r.valid;
        cd_last_i    <= r.last;
        mu_full_i    <= r.mu_full;
        su_full_i    <= r.su_full;
        for (int m = 0; m < 4; m++) begin
            beat = {lcg_next(), lcg_next()};
            cd_data_i[m] <= beat;
            // An accepted beat of the first responder goes to a consumer
            if (m == r.first && r.valid[m] && r.exp_ready[m]) begin
                expected_beats.push_back(beat);
            end
        end
        wr_issue_i   <= (r.op == OP_WR_IS);
        wr_id_i      <= r.id;
        wr_addr_i    <= r.addr;
        wr_done_i    <= (r.op == OP_WR_DN);
        wr_done_id_i <= r.id;
        rd_issue_i   <= (r.op == OP_RD_IS);
        rd_id_i      <= r.id;
        rd_addr_i    <= r.addr;
        rd_done_i    <= (r.op == OP_RD_DN);
        rd_done_id_i <= r.id;
        lookup_req_i <= r.lk_req;
        for (int p = 0; p < 4; p++) begin
            lookup_addr_i[p] <= r.lk_addr + 32'(p * 4);
        end
    endtask

    task automatic check_row(input row_t r);
        ccu_pkg::cd_data_t beat;
        compare("cd_ready_o", cd_ready_o, r.exp_ready);
        compare("mu_valid_o", mu_valid_o, r.exp_mu);
        compare("su_valid_o", su_valid_o, r.exp_su);
        compare("mu_last_o", mu_last_o, r.exp_mu && r.exp_last);
        compare("su_last_o", su_last_o, r.exp_su && r.exp_last);
        compare("cd_stall_o", cd_stall_o, r.exp_stall);
        compare("wr_full_o", wr_full_o, r.exp_wfull);
        compare("rd_full_o", rd_full_o, r.exp_rfull);
        compare("lookup_hit_o", lookup_hit_o, {4{r.exp_hit}} & r.lk_req);
        if (mu_valid_o === 1'b1 || su_valid_o === 1'b1) begin
            if (expected_beats.size() == 0) begin
                $display("Forwarded beat at %0t has no expected beat in the model", $time);
                errors++;
            end else begin
                beat = expected_beats.pop_front();
                compare("cd_data_o", cd_data_o, beat);
            end
        end
    endtask

    // Ordering queue must end empty with no ready raised
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while ((cd_stall_o || cd_ready_o != '0) && cycles < 20) begin
            @(negedge clk_i);
            cycles++;
        end
        if (cd_stall_o || cd_ready_o != '0) begin
            $display("Timeout: ordering queue did not drain within 20 cycles");
            errors++;
        end
    endtask

    initial begin
        rst_ni        = 1'b0;
        cd_push_i     = 1'b0;
        cd_user_i     = ccu_pkg::MEMORY_UNIT;
        cd_first_i    = '0;
        cd_avail_i    = '0;
        cd_valid_i    = '0;
        cd_last_i     = '0;
        cd_data_i     = '0;
        mu_full_i     = 1'b0;
        su_full_i     = 1'b0;
        wr_issue_i    = 1'b0;
        wr_id_i       = '0;
        wr_addr_i     = '0;
        wr_done_i     = 1'b0;
        wr_done_id_i  = '0;
        rd_issue_i    = 1'b0;
        rd_id_i       = '0;
        rd_addr_i     = '0;
        rd_done_i     = 1'b0;
        rd_done_id_i  = '0;
        lookup_req_i  = '0;
        lookup_addr_i = '0;
        build_table();

        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);

        ////////////////////////////////////////
        // Reset state
        ////////////////////////////////////////
        compare("cd_ready_o", cd_ready_o, 4'h0);
        compare("mu_valid_o", mu_valid_o, 1'b0);
        compare("su_valid_o", su_valid_o, 1'b0);
        compare("cd_stall_o", cd_stall_o, 1'b0);
        compare("wr_full_o", wr_full_o, 1'b0);
        compare("rd_full_o", rd_full_o, 1'b0);
        compare("lookup_hit_o", lookup_hit_o, 4'h0);

        // One row per cycle, outputs sampled mid-cycle
        foreach (rows[i]) begin
            @(posedge clk_i);
            drive_row(rows[i]);
            @(negedge clk_i);
            check_row(rows[i]);
        end

        wait_idle();
        if (expected_beats.size() != 0) begin
            $display("%0d expected beats never reached a consumer", expected_beats.size());
            errors++;
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
